/* src/display_pkg.sv */
// ----------------------------------------------------------
// display package: 640x480 60 Hz timing, flag geometry
// and the sync bundle
// ----------------------------------------------------------

package display_pkg;

    typedef logic [9:0] coord_t;  // screen coordinate, up to 1023

    // horizontal columns, 800 per line
    localparam coord_t H_ACTIVE     = 10'd640;  // first blanking column
    localparam coord_t H_SYNC_START = 10'd656;  // after 16 col front porch
    localparam coord_t H_SYNC_END   = 10'd751;  // 96 col sync pulse
    localparam coord_t H_LAST       = 10'd799;  // 48 col back porch

    // vertical lines, 525 per frame
    localparam coord_t V_ACTIVE     = 10'd480;  // first blanking line
    localparam coord_t V_SYNC_START = 10'd490;  // 10 line front porch
    localparam coord_t V_SYNC_END   = 10'd491;  // 2 line sync pulse
    localparam coord_t V_LAST       = 10'd524;  // 33 line back porch

    // flag at 16:10, 640x400 in the top of the screen
    localparam coord_t FLAG_BOTTOM  = 10'd400;  // first line below flag

    // cross bounds, exclusive on both sides
    localparam coord_t CROSS_ROW_LO = 10'd160;
    localparam coord_t CROSS_ROW_HI = 10'd240;
    localparam coord_t CROSS_COL_LO = 10'd200;
    localparam coord_t CROSS_COL_HI = 10'd280;

    // sync bundle, both syncs active low
    typedef struct packed {
        logic hsync;  // low in horizontal sync window
        logic vsync;  // low in vertical sync window
        logic de;     // high in active area
    } sync_t;

endpackage

/* src/palette_pkg.sv */
// ----------------------------------------------------------
// palette package: colour type, default colours, wishbone
// bundles and register map of the palette slave
// ----------------------------------------------------------

package palette_pkg;

    typedef logic [11:0] rgb_t;    // {r[3:0], g[3:0], b[3:0]}
    typedef logic [1:0]  wb_adr_t; // palette register address

    // default colours, swedish flag
    localparam rgb_t DEF_FIELD   = 12'h06A;  // blue
    localparam rgb_t DEF_CROSS   = 12'hFC0;  // yellow
    localparam rgb_t DEF_OUTSIDE = 12'h000;  // black

    // register map, address 3 is unused and reads zero
    localparam wb_adr_t ADR_FIELD   = 2'd0;
    localparam wb_adr_t ADR_CROSS   = 2'd1;
    localparam wb_adr_t ADR_OUTSIDE = 2'd2;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        rgb_t    dat_w;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        rgb_t dat_r;  // valid only with ack
    } wb_rsp_t;

    typedef struct packed {
        rgb_t field;      // flag background
        rgb_t cross_clr;  // flag cross
        rgb_t outside;    // lines below the flag
    } palette_t;

    localparam palette_t DEF_PALETTE = '{
        field:     DEF_FIELD,
        cross_clr: DEF_CROSS,
        outside:   DEF_OUTSIDE
    };

endpackage

/* src/display_timing.sv */
// ----------------------------------------------------------
// display timing: pixel position counters, sync windows,
// data enable and frame start for 640x480 60 Hz
// ----------------------------------------------------------

`timescale 1ns/1ps

module display_timing import display_pkg::*; (
    input  logic   clk_pix,
    input  logic   reset,
    output coord_t sx,           // current column
    output coord_t sy,           // current line
    output sync_t  sync,         // syncs and de for this position
    output logic   frame_start   // high at position (0,0)
);

    // position counters, advance every clock
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;  // (0,0) shows in first cycle after reset
        end else if (sx == H_LAST) begin
            sx <= '0;  // end of line
            if (sy == V_LAST) begin
                sy <= '0;  // end of frame
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // decode windows straight from the counters
    always_comb begin
        // active low sync pulses, bounds inclusive
        sync.hsync = ~((sx >= H_SYNC_START) && (sx <= H_SYNC_END));
        sync.vsync = ~((sy >= V_SYNC_START) && (sy <= V_SYNC_END));
        sync.de    = (sx < H_ACTIVE) && (sy < V_ACTIVE);  // visible pixels
    end

    // one pixel wide pulse per frame
    assign frame_start = (sx == '0) && (sy == '0);

endmodule

/* src/palette_regs.sv */
// ----------------------------------------------------------
// palette registers: wishbone classic slave with pending
// colours, copied to the live palette at frame start
// ----------------------------------------------------------

`timescale 1ns/1ps

module palette_regs import palette_pkg::*; (
    input  logic     clk_pix,
    input  logic     reset,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    input  logic     frame_start,
    output palette_t palette       // live palette, stable over a frame
);

    logic     req;      // request on the bus
    logic     ack;      // registered ack
    palette_t pending;  // colours written but not yet shown
    rgb_t     rd_data;

    assign req = wb_req.cyc && wb_req.stb;

    // ack one cycle after request, never two in a row
    // so a held stb is acked every second cycle
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= req && !ack;
        end
    end

    // write lands at the end of the ack cycle
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            pending <= DEF_PALETTE;
        end else if (ack && req && wb_req.we) begin
            case (wb_req.adr)
                ADR_FIELD:   pending.field     <= wb_req.dat_w;
                ADR_CROSS:   pending.cross_clr <= wb_req.dat_w;
                ADR_OUTSIDE: pending.outside   <= wb_req.dat_w;
                default:     ;  // address 3 ignores writes
            endcase
        end
    end

    // live copy only at frame start, no tearing mid frame
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            palette <= DEF_PALETTE;
        end else if (frame_start) begin
            palette <= pending;
        end
    end

    // readback of pending register
    always_comb begin
        case (wb_req.adr)
            ADR_FIELD:   rd_data = pending.field;
            ADR_CROSS:   rd_data = pending.cross_clr;
            ADR_OUTSIDE: rd_data = pending.outside;
            default:     rd_data = '0;  // unused address
        endcase
    end

    assign wb_rsp.ack   = ack;
    assign wb_rsp.dat_r = ack ? rd_data : '0;  // zero outside ack

endmodule

/* src/flag_painter.sv */
// ----------------------------------------------------------
// flag painter: palette colour per screen position for the
// swedish flag at 16:10
// ----------------------------------------------------------

`timescale 1ns/1ps

module flag_painter
    import display_pkg::*;
    import palette_pkg::*;
(
    input  coord_t   sx,
    input  coord_t   sy,
    input  palette_t palette,
    output rgb_t     colour    // combinational, not blanked
);

    logic below_flag;  // lines under the 640x400 flag
    logic cross_row;   // horizontal bar of the cross
    logic cross_col;   // vertical bar of the cross

    always_comb begin
        below_flag = (sy >= FLAG_BOTTOM);
        // bar bounds are exclusive
        cross_row  = (sy > CROSS_ROW_LO) && (sy < CROSS_ROW_HI);
        cross_col  = (sx > CROSS_COL_LO) && (sx < CROSS_COL_HI);
    end

    // priority: outside, then cross, then field
    always_comb begin
        if (below_flag) begin
            colour = palette.outside;
        end else if (cross_row || cross_col) begin
            colour = palette.cross_clr;  // either bar
        end else begin
            colour = palette.field;      // blue quarters
        end
    end

endmodule

/* src/vga_output.sv */
// ----------------------------------------------------------
// vga output stage: blanks colour and registers the pins
// ----------------------------------------------------------

`timescale 1ns/1ps

module vga_output
    import display_pkg::*;
    import palette_pkg::*;
(
    input  logic  clk_pix,
    input  logic  reset,
    input  sync_t sync,
    input  rgb_t  colour,
    output logic  vga_hsync,
    output logic  vga_vsync,
    output rgb_t  vga_rgb
);

    rgb_t blanked;  // colour with blanking applied

    // black in the blanking interval
    assign blanked = sync.de ? colour : '0;

    // one clock from counters to pins
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga_hsync <= 1'b1;  // syncs inactive
            vga_vsync <= 1'b1;
            vga_rgb   <= '0;
        end else begin
            vga_hsync <= sync.hsync;
            vga_vsync <= sync.vsync;
            vga_rgb   <= blanked;
        end
    end

endmodule

/* src/flag_display_top.sv */
// ----------------------------------------------------------
// flag display top: timing, palette slave, painter and
// vga output stage
// ----------------------------------------------------------

`timescale 1ns/1ps

module flag_display_top
    import display_pkg::*;
    import palette_pkg::*;
(
    input  logic    clk_pix,
    input  logic    reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    output logic    vga_hsync,
    output logic    vga_vsync,
    output rgb_t    vga_rgb
);

    coord_t   sx;           // pixel position
    coord_t   sy;
    sync_t    sync;         // syncs and de, unregistered
    logic     frame_start;  // pulse at (0,0)
    palette_t palette;      // live palette
    rgb_t     colour;       // painted colour

    display_timing u_timing (
        .clk_pix     (clk_pix),
        .reset       (reset),
        .sx          (sx),
        .sy          (sy),
        .sync        (sync),
        .frame_start (frame_start)
    );

    palette_regs u_palette (
        .clk_pix     (clk_pix),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .frame_start (frame_start),
        .palette     (palette)
    );

    flag_painter u_painter (
        .sx      (sx),
        .sy      (sy),
        .palette (palette),
        .colour  (colour)
    );

    vga_output u_output (
        .clk_pix   (clk_pix),
        .reset     (reset),
        .sync      (sync),
        .colour    (colour),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_rgb   (vga_rgb)
    );

endmodule

/* verif/flag_display_chk.sv */
// ----------------------------------------------------------
// flag display checker: position and palette model with
// assertions on the vga pins and the wishbone slave
// ----------------------------------------------------------

`timescale 1ns/1ps

module flag_display_chk
    import display_pkg::*;
    import palette_pkg::*;
(
    input logic    clk_pix,
    input logic    reset,
    input wb_req_t wb_req,
    input wb_rsp_t wb_rsp,
    input logic    vga_hsync,
    input logic    vga_vsync,
    input rgb_t    vga_rgb
);

    logic     armed  = 1'b0;  // reset seen once
    logic     rst_d  = 1'b0;  // reset at last edge
    logic     failed = 1'b0;  // polled by the testbench
    logic     open_d;         // request without ack at last edge
    logic     req;
    logic     chk_en;
    coord_t   mx;             // model of the counters
    coord_t   my;
    coord_t   px;             // position now on the pins
    coord_t   py;
    palette_t pend;           // model pending palette
    palette_t live;           // model live palette
    palette_t plive;          // live palette behind the pins

    assign req    = wb_req.cyc && wb_req.stb;
    assign chk_en = armed && !rst_d;  // pins carry a counted position

    // swedish flag rule
    function automatic rgb_t paint(input coord_t x, input coord_t y, input palette_t pal);
        rgb_t c;
        if (y >= FLAG_BOTTOM)
            c = pal.outside;
        else if (((y > CROSS_ROW_LO) && (y < CROSS_ROW_HI)) ||
                 ((x > CROSS_COL_LO) && (x < CROSS_COL_HI)))
            c = pal.cross_clr;  // either bar
        else
            c = pal.field;
        return c;
    endfunction

    // register map as seen on a read
    function automatic rgb_t reg_value(input wb_adr_t a, input palette_t pal);
        case (a)
            ADR_FIELD:   return pal.field;
            ADR_CROSS:   return pal.cross_clr;
            ADR_OUTSIDE: return pal.outside;
            default:     return '0;  // unused slot
        endcase
    endfunction

    always @(posedge clk_pix) begin
        rst_d  <= reset;
        open_d <= req && !wb_rsp.ack;  // ack due next cycle
        px     <= mx;
        py     <= my;
        plive  <= live;
        if (reset) begin
            armed <= 1'b1;
            mx    <= '0;
            my    <= '0;
            pend  <= DEF_PALETTE;
            live  <= DEF_PALETTE;
        end else begin
            if (mx == H_LAST) begin
                mx <= '0;
                my <= (my == V_LAST) ? '0 : my + 10'd1;
            end else begin
                mx <= mx + 10'd1;
            end
            if (wb_rsp.ack && req && wb_req.we) begin
                case (wb_req.adr)
                    ADR_FIELD:   pend.field     <= wb_req.dat_w;
                    ADR_CROSS:   pend.cross_clr <= wb_req.dat_w;
                    ADR_OUTSIDE: pend.outside   <= wb_req.dat_w;
                    default:     ;
                endcase
            end
            if ((mx == '0) && (my == '0))
                live <= pend;  // frame start
        end
    end

    a_reset: assert property (@(posedge clk_pix) rst_d |->
        vga_hsync && vga_vsync && (vga_rgb == '0) && !wb_rsp.ack)
        else begin
            $error("pins or ack not idle around reset");
            failed = 1'b1;
        end

    a_sync: assert property (@(posedge clk_pix) chk_en |->
        (vga_hsync == !((px >= H_SYNC_START) && (px <= H_SYNC_END))) &&
        (vga_vsync == !((py >= V_SYNC_START) && (py <= V_SYNC_END))))
        else begin
            $error("sync at (%0d,%0d) off", px, py);
            failed = 1'b1;
        end

    a_paint: assert property (@(posedge clk_pix)
        chk_en && (px < H_ACTIVE) && (py < V_ACTIVE) |-> vga_rgb == paint(px, py, plive))
        else begin
            $error("colour %h at (%0d,%0d)", vga_rgb, px, py);
            failed = 1'b1;
        end

    a_blank: assert property (@(posedge clk_pix)
        chk_en && !((px < H_ACTIVE) && (py < V_ACTIVE)) |-> vga_rgb == '0)
        else begin
            $error("colour %h in blanking", vga_rgb);
            failed = 1'b1;
        end

    a_ack: assert property (@(posedge clk_pix) chk_en |-> wb_rsp.ack == open_d)
        else begin
            $error("ack out of step with the request");
            failed = 1'b1;
        end

    a_read: assert property (@(posedge clk_pix) chk_en && wb_rsp.ack && req && !wb_req.we |->
        wb_rsp.dat_r == reg_value(wb_req.adr, pend))
        else begin
            $error("read data %h at address %0d", wb_rsp.dat_r, wb_req.adr);
            failed = 1'b1;
        end

endmodule

bind flag_display_top flag_display_chk u_chk (.*);

/* verif/flag_display_tb.sv */
// ----------------------------------------------------------
// testbench for the flag display with palette writes and
// readback over wishbone across three frames of video
// ----------------------------------------------------------

`timescale 1ns/1ps

module flag_display_tb
    import display_pkg::*;
    import palette_pkg::*;
();

    localparam int LINE_CYCLES  = int'(H_LAST) + 1;
    localparam int FRAME_CYCLES = LINE_CYCLES * (int'(V_LAST) + 1);
    localparam int ACK_TIMEOUT  = 8;  // ack is due after one cycle

    logic    clk_pix = 1'b0;
    logic    reset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    vga_hsync;
    logic    vga_vsync;
    rgb_t    vga_rgb;
    integer  seed;
    rgb_t    expect_reg [4];  // last value written per address

    flag_display_top dut (.*);

    always #20 clk_pix = ~clk_pix;  // 25 MHz pixel clock

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    // checker flags land on the rising edge
    always @(negedge clk_pix) begin
        if (dut.u_chk.failed)
            abort_run($sformatf("checker assertion failed near %0t", $time));
    end

    // through one vsync pulse up to its rising edge
    task automatic wait_frame();
        int n;
        n = 0;
        while (vga_vsync) begin
            @(negedge clk_pix);
            n++;
            if (n > FRAME_CYCLES)
                abort_run("timeout, no vsync pulse within a frame");
        end
        n = 0;
        while (!vga_vsync) begin
            @(negedge clk_pix);
            n++;
            if (n > 4 * LINE_CYCLES)
                abort_run("timeout, vsync stuck low");
        end
    endtask

    task automatic wait_lines(input int lines);
        int n;
        repeat (lines) begin
            n = 0;
            while (vga_hsync) begin
                @(negedge clk_pix);
                n++;
                if (n > LINE_CYCLES)
                    abort_run("timeout, no hsync pulse within a line");
            end
            n = 0;
            while (!vga_hsync) begin
                @(negedge clk_pix);
                n++;
                if (n > LINE_CYCLES)
                    abort_run("timeout, hsync stuck low");
            end
        end
    endtask

    // classic cycle with stb dropped after the ack edge or held for more acks
    task automatic bus_access(input logic we, input wb_adr_t adr, input rgb_t wdat,
                              input int hold, output rgb_t rdat);
        int n;
        @(negedge clk_pix);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdat};
        n = 0;
        do begin
            @(negedge clk_pix);
            n++;
            if (n > ACK_TIMEOUT)
                abort_run("timeout, wishbone request never acknowledged");
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat_r;  // valid in the ack cycle
        repeat (2 * hold) @(negedge clk_pix);  // each held request acked in full
        @(negedge clk_pix);
        wb_req = '0;
    endtask

    task automatic write_colour(input wb_adr_t adr, input rgb_t colour, input int hold);
        rgb_t unused;
        bus_access(1'b1, adr, colour, hold, unused);
        if (adr != 2'd3)
            expect_reg[adr] = colour;  // slot 3 drops writes
    endtask

    task automatic read_check(input wb_adr_t adr, input int hold);
        rgb_t got;
        bus_access(1'b0, adr, '0, hold, got);
        if (got !== expect_reg[adr])
            abort_run($sformatf("FAILED at %0t: address %0d read %h, expected %h",
                                $time, adr, got, expect_reg[adr]));
    endtask

    initial begin
        int rnd;
        seed          = 27478;
        reset         = 1'b1;
        wb_req        = '0;
        expect_reg[0] = DEF_FIELD;
        expect_reg[1] = DEF_CROSS;
        expect_reg[2] = DEF_OUTSIDE;
        expect_reg[3] = '0;
        repeat (5) @(posedge clk_pix);
        @(negedge clk_pix);
        reset = 1'b0;
        wait_frame();     // default colours
        wait_lines(120);  // visible lines of the next frame
        for (int a = 0; a < 4; a++) begin
            rnd = $random(seed);
            write_colour(wb_adr_t'(a), rnd[11:0], rnd[12] ? int'(rnd[15:13]) : 0);
        end
        for (int a = 0; a < 4; a++) begin
            rnd = $random(seed);
            read_check(wb_adr_t'(a), rnd[12] ? int'(rnd[15:13]) : 0);
        end
        wait_frame();  // rest of the frame keeps old colours
        wait_frame();  // new colours from (0,0)
        if (dut.u_chk.failed) begin
            $display(">>> FAIL");
            $fatal(1, "checker reported errors");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* verilog.f */
src/display_pkg.sv
src/palette_pkg.sv
src/display_timing.sv
src/palette_regs.sv
src/flag_painter.sv
src/vga_output.sv
src/flag_display_top.sv
verif/flag_display_chk.sv
verif/flag_display_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module flag_display_tb -f verilog.f -o flag_display_sim
	./obj_dir/flag_display_sim +verilator+error+limit+10

clean:
	rm -rf obj_dir
